//--- hw/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    parameter int XLEN   = 32;
    parameter int HIST_W = 16; // low byte short history, high byte long history
    parameter int TAG_W  = 10;

    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_JAL    = 7'b1101111;

    // which table supplied the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    typedef struct packed {
        logic       imm12;    // inst[31]
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;    // inst[7]
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;    // inst[31]
        logic [9:0] imm10_1;
        logic       imm11;    // inst[20]
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one fetched word, read as B-type or J-type
    typedef union packed {
        b_type_t b;
        j_type_t j;
    } rv_inst_u;

    typedef struct packed {
        logic              is_ctrl;
        logic              taken;
        logic [XLEN-1:0]   target;
        provider_e         provider;
        logic [HIST_W-1:0] history; // snapshot handed back with the update
    } bpu_pred_t;

    typedef struct packed {
        logic              valid;   // one-cycle strobe per resolved branch
        logic              taken;
        logic              correct; // direction was right
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   target;
        logic [HIST_W-1:0] history;
        provider_e         provider;
    } bpu_update_t;

    typedef struct packed {
        logic [31:0] total;
        logic [31:0] correct;
        logic [31:0] bimodal_ok;
        logic [31:0] t0_ok;
        logic [31:0] t1_ok;
    } bpu_stats_t;

endpackage

`default_nettype wire

//--- hw/bpu_predecode.sv
`default_nettype none

module bpu_predecode (
    input  wire bpu_pkg::rv_inst_u         inst_i,
    input  wire logic [bpu_pkg::XLEN-1:0]  pc_i,
    output logic                           is_branch_o,
    output logic                           is_jal_o,
    output logic [bpu_pkg::XLEN-1:0]       seq_pc_o,
    output logic [bpu_pkg::XLEN-1:0]       imm_target_o
);

    localparam int XLEN = bpu_pkg::XLEN;

    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] offset;

    // opcode sits in the same bits for both views
    assign is_branch_o = (inst_i.b.opcode == bpu_pkg::OPC_BRANCH);
    assign is_jal_o    = (inst_i.j.opcode == bpu_pkg::OPC_JAL);

    // B immediate, 13 bits with lsb zero
    assign b_imm = {
        {(XLEN-12){inst_i.b.imm12}},
        inst_i.b.imm11,
        inst_i.b.imm10_5,
        inst_i.b.imm4_1,
        1'b0
    };

    // J immediate, 21 bits with lsb zero
    assign j_imm = {
        {(XLEN-20){inst_i.j.imm20}},
        inst_i.j.imm19_12,
        inst_i.j.imm11,
        inst_i.j.imm10_1,
        1'b0
    };

    assign offset = is_jal_o ? j_imm : b_imm;

    assign seq_pc_o     = pc_i + XLEN'(4);
    assign imm_target_o = pc_i + offset; // only meaningful for branch or jal

endmodule

`default_nettype wire

//--- hw/bpu_direction.sv
`default_nettype none

module bpu_direction #(
    parameter int TAGE_IDX_W = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [bpu_pkg::XLEN-1:0]    pc_i,
    input  wire bpu_pkg::bpu_update_t        upd_i,
    output logic                             taken_o,
    output bpu_pkg::provider_e               provider_o,
    output logic [bpu_pkg::HIST_W-1:0]       history_o
);

    localparam int XLEN      = bpu_pkg::XLEN;
    localparam int HIST_W    = bpu_pkg::HIST_W;
    localparam int TAG_W     = bpu_pkg::TAG_W;
    localparam int BIM_IDX_W = TAGE_IDX_W + 1; // bimodal has twice the entries
    localparam int TAGE_N    = 1 << TAGE_IDX_W;
    localparam int BIM_N     = 1 << BIM_IDX_W;

    logic [HIST_W-1:0] ghist;

    logic [1:0]       bim_ctr [BIM_N];
    logic [1:0]       t0_ctr  [TAGE_N];
    logic [1:0]       t1_ctr  [TAGE_N];
    logic             t0_vld  [TAGE_N];
    logic             t1_vld  [TAGE_N];
    logic [TAG_W-1:0] t0_tag  [TAGE_N];
    logic [TAG_W-1:0] t1_tag  [TAGE_N];

    // fit a history byte to the index width
    function automatic logic [TAGE_IDX_W-1:0] hist_fold(input logic [7:0] h);
        logic [TAGE_IDX_W+7:0] ext;
        ext = {{TAGE_IDX_W{1'b0}}, h};
        return ext[TAGE_IDX_W-1:0];
    endfunction

    function automatic logic [BIM_IDX_W-1:0] bim_index(input logic [XLEN-1:0] pc);
        return pc[BIM_IDX_W:1];
    endfunction

    function automatic logic [TAGE_IDX_W-1:0] t0_index(input logic [XLEN-1:0] pc,
                                                       input logic [HIST_W-1:0] h);
        return pc[TAGE_IDX_W+1:2] ^ hist_fold(h[7:0]);
    endfunction

    function automatic logic [TAGE_IDX_W-1:0] t1_index(input logic [XLEN-1:0] pc,
                                                       input logic [HIST_W-1:0] h);
        return pc[TAGE_IDX_W+1:2] ^ hist_fold(h[15:8]);
    endfunction

    function automatic logic [TAG_W-1:0] t0_tag_of(input logic [XLEN-1:0] pc,
                                                   input logic [HIST_W-1:0] h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic logic [TAG_W-1:0] t1_tag_of(input logic [XLEN-1:0] pc,
                                                   input logic [HIST_W-1:0] h);
        return pc[17:8] ^ {{(TAG_W-8){1'b0}}, h[7:0]};
    endfunction

    // 2-bit saturating step
    function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    // lookup with the current history
    logic [BIM_IDX_W-1:0]  l_bim_idx;
    logic [TAGE_IDX_W-1:0] l_t0_idx;
    logic [TAGE_IDX_W-1:0] l_t1_idx;
    logic                  t0_hit;
    logic                  t1_hit;

    assign l_bim_idx = bim_index(pc_i);
    assign l_t0_idx  = t0_index(pc_i, ghist);
    assign l_t1_idx  = t1_index(pc_i, ghist);

    assign t0_hit = t0_vld[l_t0_idx] && (t0_tag[l_t0_idx] == t0_tag_of(pc_i, ghist));
    assign t1_hit = t1_vld[l_t1_idx] && (t1_tag[l_t1_idx] == t1_tag_of(pc_i, ghist));

    always_comb begin
        if (t1_hit) begin // longest history wins
            provider_o = bpu_pkg::PROV_T1;
            taken_o    = t1_ctr[l_t1_idx][1];
        end else if (t0_hit) begin
            provider_o = bpu_pkg::PROV_T0;
            taken_o    = t0_ctr[l_t0_idx][1];
        end else begin
            provider_o = bpu_pkg::PROV_BIMODAL;
            taken_o    = bim_ctr[l_bim_idx][1];
        end
    end

    assign history_o = ghist;

    // update with the snapshot from prediction time
    logic [BIM_IDX_W-1:0]  u_bim_idx;
    logic [TAGE_IDX_W-1:0] u_t0_idx;
    logic [TAGE_IDX_W-1:0] u_t1_idx;
    logic [TAG_W-1:0]      u_t0_tag;
    logic [TAG_W-1:0]      u_t1_tag;
    logic                  alloc;
    logic                  alloc_t1;

    assign u_bim_idx = bim_index(upd_i.pc);
    assign u_t0_idx  = t0_index(upd_i.pc, upd_i.history);
    assign u_t1_idx  = t1_index(upd_i.pc, upd_i.history);
    assign u_t0_tag  = t0_tag_of(upd_i.pc, upd_i.history);
    assign u_t1_tag  = t1_tag_of(upd_i.pc, upd_i.history);

    // bimodal miss allocates into T1 unless T1 already holds this tag
    assign alloc    = upd_i.valid && !upd_i.correct
                      && (upd_i.provider == bpu_pkg::PROV_BIMODAL);
    assign alloc_t1 = !t1_vld[u_t1_idx] || (t1_tag[u_t1_idx] != u_t1_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < BIM_N; i++) begin
                bim_ctr[i] <= 2'b01; // weakly not-taken
            end
            for (int i = 0; i < TAGE_N; i++) begin
                t0_ctr[i] <= 2'b01;
                t1_ctr[i] <= 2'b01;
                t0_vld[i] <= 1'b0;
                t1_vld[i] <= 1'b0;
            end
        end else if (upd_i.valid) begin
            ghist <= {ghist[HIST_W-2:0], upd_i.taken};
            bim_ctr[u_bim_idx] <= ctr_step(bim_ctr[u_bim_idx], upd_i.taken);
            if (upd_i.provider == bpu_pkg::PROV_T1) begin
                t1_ctr[u_t1_idx] <= upd_i.correct ? ctr_step(t1_ctr[u_t1_idx], upd_i.taken)
                                                  : {2{upd_i.taken}}; // strong on miss
            end else if (upd_i.provider == bpu_pkg::PROV_T0) begin
                t0_ctr[u_t0_idx] <= upd_i.correct ? ctr_step(t0_ctr[u_t0_idx], upd_i.taken)
                                                  : {2{upd_i.taken}};
            end else if (alloc) begin
                if (alloc_t1) begin
                    t1_ctr[u_t1_idx] <= {upd_i.taken, !upd_i.taken}; // weak in actual dir
                    t1_vld[u_t1_idx] <= 1'b1;
                end else begin
                    t0_ctr[u_t0_idx] <= {upd_i.taken, !upd_i.taken};
                    t0_vld[u_t0_idx] <= 1'b1;
                end
            end
        end
    end

    // tag write on allocation
    always_ff @(posedge clk) begin
        if (alloc) begin
            if (alloc_t1) begin
                t1_tag[u_t1_idx] <= u_t1_tag;
            end else begin
                t0_tag[u_t0_idx] <= u_t0_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/bpu_btb.sv
`default_nettype none

module bpu_btb #(
    parameter int BTB_IDX_W = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [bpu_pkg::XLEN-1:0]   pc_i,
    input  wire bpu_pkg::bpu_update_t       upd_i,
    output logic                            hit_o,
    output logic [bpu_pkg::XLEN-1:0]        target_o
);

    localparam int XLEN      = bpu_pkg::XLEN;
    localparam int BTB_N     = 1 << BTB_IDX_W;
    localparam int BTB_TAG_W = XLEN - 18; // pc[31:18]

    logic [BTB_TAG_W-1:0] tag_mem    [BTB_N];
    logic [XLEN-1:0]      target_mem [BTB_N];
    logic                 vld        [BTB_N];

    logic [BTB_IDX_W-1:0] l_idx;
    logic [BTB_TAG_W-1:0] l_tag;
    logic [BTB_IDX_W-1:0] u_idx;
    logic [BTB_TAG_W-1:0] u_tag;
    logic                 fill;

    assign l_idx = pc_i[BTB_IDX_W+1:2];
    assign l_tag = pc_i[XLEN-1:18];
    assign u_idx = upd_i.pc[BTB_IDX_W+1:2];
    assign u_tag = upd_i.pc[XLEN-1:18];

    // only taken outcomes carry a useful target
    assign fill = upd_i.valid && upd_i.taken;

    // combinational lookup
    assign hit_o    = vld[l_idx] && (tag_mem[l_idx] == l_tag);
    assign target_o = target_mem[l_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_N; i++) begin
                vld[i] <= 1'b0;
            end
        end else if (fill) begin
            vld[u_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[u_idx]    <= u_tag;
            target_mem[u_idx] <= upd_i.target;
        end
    end

endmodule

`default_nettype wire

//--- hw/bpu_stats.sv
`default_nettype none

module bpu_stats (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire bpu_pkg::bpu_pred_t    pred_i,
    input  wire logic                  btb_hit_i,
    input  wire bpu_pkg::bpu_update_t  upd_i,
    output bpu_pkg::bpu_stats_t        stats_o,
    output logic [31:0]                btb_hits_o,
    output logic [31:0]                btb_misses_o
);

    logic taken_ctrl;

    assign taken_ctrl = pred_i.is_ctrl && pred_i.taken;

    // resolved branch counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stats_o <= '0;
        end else if (upd_i.valid) begin
            stats_o.total <= stats_o.total + 32'd1;
            if (upd_i.correct) begin
                stats_o.correct <= stats_o.correct + 32'd1;
                case (upd_i.provider)
                    bpu_pkg::PROV_T0: stats_o.t0_ok <= stats_o.t0_ok + 32'd1;
                    bpu_pkg::PROV_T1: stats_o.t1_ok <= stats_o.t1_ok + 32'd1;
                    default:          stats_o.bimodal_ok <= stats_o.bimodal_ok + 32'd1;
                endcase
            end
        end
    end

    // sampled every cycle the fetch side predicts a taken redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btb_hits_o   <= '0;
            btb_misses_o <= '0;
        end else if (taken_ctrl) begin
            if (btb_hit_i) begin
                btb_hits_o <= btb_hits_o + 32'd1;
            end else begin
                btb_misses_o <= btb_misses_o + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/bpu_top.sv
`default_nettype none

module bpu_top #(
    parameter int TAGE_IDX_W = 8,
    parameter int BTB_IDX_W  = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  wire bpu_pkg::rv_inst_u          if_inst_i,
    input  wire bpu_pkg::bpu_update_t       upd_i,
    output bpu_pkg::bpu_pred_t              pred_o,
    output bpu_pkg::bpu_stats_t             stats_o,
    output logic [31:0]                     btb_hits_o,
    output logic [31:0]                     btb_misses_o
);

    localparam int XLEN = bpu_pkg::XLEN;

    logic                         is_branch;
    logic                         is_jal;
    logic [XLEN-1:0]              seq_pc;
    logic [XLEN-1:0]              imm_target;
    logic                         dir_taken;
    bpu_pkg::provider_e           provider;
    logic [bpu_pkg::HIST_W-1:0]   history;
    logic                         btb_hit;
    logic [XLEN-1:0]              btb_target;

    bpu_predecode bpu_predecode_i (
        .inst_i       (if_inst_i),
        .pc_i         (if_pc_i),
        .is_branch_o  (is_branch),
        .is_jal_o     (is_jal),
        .seq_pc_o     (seq_pc),
        .imm_target_o (imm_target)
    );

    bpu_direction #(
        .TAGE_IDX_W (TAGE_IDX_W)
    ) bpu_direction_i (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (if_pc_i),
        .upd_i      (upd_i),
        .taken_o    (dir_taken),
        .provider_o (provider),
        .history_o  (history)
    );

    bpu_btb #(
        .BTB_IDX_W (BTB_IDX_W)
    ) bpu_btb_i (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .upd_i    (upd_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    always_comb begin
        pred_o.is_ctrl  = is_branch || is_jal;
        pred_o.taken    = is_jal || (is_branch && dir_taken); // jal always taken
        pred_o.provider = provider;
        pred_o.history  = history;
        if (!pred_o.taken) begin
            pred_o.target = seq_pc;
        end else if (btb_hit) begin
            pred_o.target = btb_target;
        end else begin
            pred_o.target = imm_target; // decoded offset on a btb miss
        end
    end

    bpu_stats bpu_stats_i (
        .clk          (clk),
        .rst          (rst),
        .pred_i       (pred_o),
        .btb_hit_i    (btb_hit),
        .upd_i        (upd_i),
        .stats_o      (stats_o),
        .btb_hits_o   (btb_hits_o),
        .btb_misses_o (btb_misses_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_bpu.sv
`default_nettype none

module tb_bpu;

    localparam int TAGE_IDX_W = 8;
    localparam int BTB_IDX_W  = 8;
    localparam int RAND_N     = 24;
    // reset, tests 1 to 3, random sequence, history flush plus t1 test, margin
    localparam int CYCLE_LIMIT = 4 + 4 + 3 + 4 + 2 * RAND_N + (bpu_pkg::HIST_W + 3) + 16;
    localparam logic [31:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

    logic                    clk;
    logic                    rst;
    logic [31:0]             if_pc_i;
    bpu_pkg::rv_inst_u       if_inst_i;
    bpu_pkg::bpu_update_t    upd_i;
    bpu_pkg::bpu_pred_t      pred_o;
    bpu_pkg::bpu_stats_t     stats_o;
    logic [31:0]             btb_hits_o;
    logic [31:0]             btb_misses_o;

    // reference model state
    logic [15:0]             hist_m;
    bpu_pkg::bpu_stats_t     stats_m;
    logic [31:0]             hits_m;
    logic [31:0]             misses_m;
    logic [31:0]             lcg_state = 32'd17;
    int                      cycle_cnt = 0;

    bpu_top #(
        .TAGE_IDX_W (TAGE_IDX_W),
        .BTB_IDX_W  (BTB_IDX_W)
    ) bpu_top_i (
        .clk          (clk),
        .rst          (rst),
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .upd_i        (upd_i),
        .pred_o       (pred_o),
        .stats_o      (stats_o),
        .btb_hits_o   (btb_hits_o),
        .btb_misses_o (btb_misses_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] r);
        return {{11{r[20]}}, r[20:1], 1'b0};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] r);
        return {{19{r[12]}}, r[12:1], 1'b0};
    endfunction

    // jal x1, off
    function automatic logic [31:0] enc_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, bpu_pkg::OPC_JAL};
    endfunction

    // beq x1, x2, off
    function automatic logic [31:0] enc_branch(input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], bpu_pkg::OPC_BRANCH};
    endfunction

    function automatic bpu_pkg::bpu_pred_t make_pred(input logic ctrl, input logic taken,
                                                     input logic [31:0] target,
                                                     input bpu_pkg::provider_e prov);
        bpu_pkg::bpu_pred_t p;
        p.is_ctrl  = ctrl;
        p.taken    = taken;
        p.target   = target;
        p.provider = prov;
        p.history  = hist_m; // model history at prediction time
        return p;
    endfunction

    function automatic bpu_pkg::bpu_update_t make_update(input logic [31:0] pc, input logic taken,
                                                         input logic correct,
                                                         input logic [31:0] target,
                                                         input bpu_pkg::provider_e prov);
        bpu_pkg::bpu_update_t u;
        u.valid    = 1'b1;
        u.taken    = taken;
        u.correct  = correct;
        u.pc       = pc;
        u.target   = target;
        u.history  = hist_m;
        u.provider = prov;
        return u;
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_pred(input bpu_pkg::bpu_pred_t got, input bpu_pkg::bpu_pred_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR pred_o (%s) got %h expected %h", what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stats(input bpu_pkg::bpu_stats_t got, input bpu_pkg::bpu_stats_t exp);
        if (got !== exp) begin
            $display("ERROR stats_o got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_btb(input logic [31:0] hits, input logic [31:0] misses);
        if (hits !== hits_m || misses !== misses_m) begin
            $display("ERROR btb_hits_o/btb_misses_o got %h/%h expected %h/%h",
                     hits, misses, hits_m, misses_m);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic train_model(input bpu_pkg::bpu_update_t u);
        hist_m        = {hist_m[14:0], u.taken};
        stats_m.total = stats_m.total + 32'd1;
        if (u.correct) begin
            stats_m.correct = stats_m.correct + 32'd1;
            if (u.provider == bpu_pkg::PROV_T1) begin
                stats_m.t1_ok = stats_m.t1_ok + 32'd1;
            end else if (u.provider == bpu_pkg::PROV_T0) begin
                stats_m.t0_ok = stats_m.t0_ok + 32'd1;
            end else begin
                stats_m.bimodal_ok = stats_m.bimodal_ok + 32'd1;
            end
        end
    endtask

    // one-cycle feedback strobe
    task automatic send_update(input bpu_pkg::bpu_update_t u);
        upd_i = u;
        next_cycle();
        upd_i.valid = 1'b0;
        train_model(u);
    endtask

    // word is held one cycle so the stats edge sees it, then back to a nop
    task automatic predict_and_check(input logic [31:0] pc, input logic [31:0] inst,
                                     input bpu_pkg::bpu_pred_t exp, input string what);
        if_pc_i   = pc;
        if_inst_i = inst;
        #1;
        check_pred(pred_o, exp, what);
        next_cycle();
        if_inst_i = NOP_WORD;
    endtask

    task automatic test_non_ctrl_and_jal();
        logic [31:0] pc;
        logic [31:0] off;
        for (int n = 0; n < 3; n++) begin
            pc = lcg_next() & 32'hFFFF_FDFC;
            predict_and_check(pc, NOP_WORD,
                              make_pred(1'b0, 1'b0, pc + 32'd4, bpu_pkg::PROV_BIMODAL), "nop");
        end
        pc  = lcg_next() & 32'hFFFF_FDFC;
        off = jal_offset(lcg_next());
        predict_and_check(pc, enc_jal(off),
                          make_pred(1'b1, 1'b1, pc + off, bpu_pkg::PROV_BIMODAL), "jal");
        misses_m = misses_m + 32'd1; // empty btb
    endtask

    task automatic test_bimodal_train();
        logic [31:0] pc;
        logic [31:0] off;
        pc  = 32'h0000_0120;
        off = branch_offset(lcg_next());
        predict_and_check(pc, enc_branch(off),
                          make_pred(1'b1, 1'b0, pc + 32'd4, bpu_pkg::PROV_BIMODAL), "fresh br");
        send_update(make_update(pc, 1'b1, 1'b1, pc + off, bpu_pkg::PROV_BIMODAL));
        predict_and_check(pc, enc_branch(off),
                          make_pred(1'b1, 1'b1, pc + off, bpu_pkg::PROV_BIMODAL), "trained br");
        hits_m = hits_m + 32'd1;
    endtask

    task automatic test_btb_fill();
        logic [31:0] pc;
        logic [31:0] alias_pc;
        logic [31:0] off;
        logic [31:0] tgt;
        pc       = 32'h0000_1100;
        alias_pc = pc ^ 32'h0004_0000; // same index, other tag
        tgt      = 32'h0000_8000;
        off      = jal_offset(lcg_next());
        predict_and_check(pc, enc_jal(off),
                          make_pred(1'b1, 1'b1, pc + off, bpu_pkg::PROV_BIMODAL), "jal no fill");
        misses_m = misses_m + 32'd1;
        send_update(make_update(pc, 1'b1, 1'b1, tgt, bpu_pkg::PROV_BIMODAL));
        predict_and_check(pc, enc_jal(off),
                          make_pred(1'b1, 1'b1, tgt, bpu_pkg::PROV_BIMODAL), "jal filled");
        hits_m = hits_m + 32'd1;
        predict_and_check(alias_pc, enc_jal(off),
                          make_pred(1'b1, 1'b1, alias_pc + off, bpu_pkg::PROV_BIMODAL), "alias");
        misses_m = misses_m + 32'd1;
        check_btb(btb_hits_o, btb_misses_o);
    endtask

    task automatic test_random_history();
        logic [31:0]        r;
        logic [31:0]        pc;
        bpu_pkg::provider_e prov;
        for (int n = 0; n < RAND_N; n++) begin
            r  = lcg_next();
            pc = lcg_next() & 32'hFFFF_FDFC; // bit 9 clear keeps it off the t1 test pc
            if (!r[16]) begin
                prov = r[17] ? bpu_pkg::PROV_T1 : bpu_pkg::PROV_T0; // miss without allocation
            end else if (r[18:17] == 2'd1) begin
                prov = bpu_pkg::PROV_T0;
            end else if (r[18:17] == 2'd2) begin
                prov = bpu_pkg::PROV_T1;
            end else begin
                prov = bpu_pkg::PROV_BIMODAL;
            end
            send_update(make_update(pc, r[20], r[16], lcg_next(), prov));
            pc = lcg_next() & 32'hFFFF_FDFC;
            predict_and_check(pc, NOP_WORD,
                              make_pred(1'b0, 1'b0, pc + 32'd4, bpu_pkg::PROV_BIMODAL), "history");
        end
    endtask

    task automatic test_t1_alloc();
        logic [31:0] pc;
        logic [31:0] off;
        pc  = 32'h0000_0A40;
        off = branch_offset(lcg_next());
        // all ones history so a taken miss keeps the snapshot
        for (int n = 0; n < bpu_pkg::HIST_W; n++) begin
            send_update(make_update(32'h0000_0B80, 1'b1, 1'b1, 32'h0000_0400,
                                    bpu_pkg::PROV_BIMODAL));
        end
        predict_and_check(pc, enc_branch(off),
                          make_pred(1'b1, 1'b0, pc + 32'd4, bpu_pkg::PROV_BIMODAL), "pre miss");
        send_update(make_update(pc, 1'b1, 1'b0, pc + off, bpu_pkg::PROV_BIMODAL));
        predict_and_check(pc, enc_branch(off),
                          make_pred(1'b1, 1'b1, pc + off, bpu_pkg::PROV_T1), "t1 alloc");
        hits_m = hits_m + 32'd1; // filled by the miss update
    endtask

    initial begin
        rst       = 1'b1;
        if_pc_i   = '0;
        if_inst_i = NOP_WORD;
        upd_i     = '0;
        hist_m    = '0;
        stats_m   = '0;
        hits_m    = '0;
        misses_m  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_non_ctrl_and_jal();
        test_bimodal_train();
        test_btb_fill();
        test_random_history();
        test_t1_alloc();

        check_stats(stats_o, stats_m);
        check_btb(btb_hits_o, btb_misses_o);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/bpu_pkg.sv
hw/bpu_predecode.sv
hw/bpu_direction.sv
hw/bpu_btb.sv
hw/bpu_stats.sv
hw/bpu_top.sv
testbench/tb_bpu.sv

//--- run_sim.sh
#!/bin/sh
# builds the bpu testbench with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_bpu -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_bpu)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
